// File: design/control_encoder.sv
`timescale 1ns/10ps
`include "control_unit_macros.svh"

module control_encoder (
    input  control_unit_pkg::ctrl_state_t state,
    output logic                          pc_write,
    output logic                          pc_write_cond,
    output logic                          pc_source,
    output logic                          ir_write,
    output logic                          reg_write,
    output logic                          memory_read,
    output logic                          memory_write,
    output logic                          is_immediate,
    output logic                          csr_write_enable,
    output logic                          save_address,
    output logic                          mdu_start,
    output control_unit_pkg::addr_sel_t   lord,
    output control_unit_pkg::aluop_t      aluop,
    output control_unit_pkg::alu_src_t    alu_src_a,
    output control_unit_pkg::alu_src_t    alu_src_b,
    output control_unit_pkg::wb_src_t     memory_to_reg
);

    import control_unit_pkg::*;

    always_comb begin
        pc_write         = 1'b0;
        pc_write_cond    = 1'b0;
        pc_source        = 1'b0;
        ir_write         = 1'b0;
        reg_write        = 1'b0;
        memory_read      = 1'b0;
        memory_write     = 1'b0;
        is_immediate     = 1'b0;
        csr_write_enable = 1'b0;
        save_address     = 1'b0;
        mdu_start        = 1'b0;
        lord             = `ADDR_PC;
        aluop            = `ALUOP_ADD;
        alu_src_a        = `SRC_A_PC;
        alu_src_b        = `SRC_B_RS2;
        memory_to_reg    = `WB_ALU;
        case (state)
            FETCH: begin
                memory_read = 1'b1;
            end
            VALIDATE_FETCH: begin
                memory_read = 1'b1;
                ir_write    = 1'b1;
                pc_write    = 1'b1; // PC + 4 goes to the PC with the IR load
                alu_src_b   = `SRC_B_FOUR;
            end
            DECODE: begin
                alu_src_a = `SRC_A_OLD_PC; // Branch and JAL target ahead of time
                alu_src_b = `SRC_B_IMM;
            end
            MEMADR: begin
                alu_src_a    = `SRC_A_RS1;
                alu_src_b    = `SRC_B_IMM;
                save_address = 1'b1;
            end
            MEMREAD: begin
                memory_read = 1'b1;
                lord        = `ADDR_ALU;
            end
            MEMWRITE: begin
                memory_write = 1'b1;
                lord         = `ADDR_ALU;
            end
            MEMWB: begin
                reg_write     = 1'b1;
                memory_to_reg = `WB_MEM;
            end
            EXECUTER: begin
                alu_src_a = `SRC_A_RS1;
                aluop     = `ALUOP_FUNCT;
            end
            EXECUTEI: begin
                alu_src_a    = `SRC_A_RS1;
                alu_src_b    = `SRC_B_IMM;
                aluop        = `ALUOP_FUNCT;
                is_immediate = 1'b1;
            end
            ALUWB: begin
                reg_write = 1'b1;
            end
            JAL: begin
                alu_src_a = `SRC_A_OLD_PC; // Link value is old PC + 4
                alu_src_b = `SRC_B_FOUR;
                pc_write  = 1'b1;
                pc_source = 1'b1;
            end
            BRANCH: begin
                alu_src_a     = `SRC_A_RS1;
                aluop         = `ALUOP_BRANCH;
                pc_write_cond = 1'b1;
                pc_source     = 1'b1;
            end
            JALR_PC: begin
                alu_src_a = `SRC_A_RS1; // rs1 + imm lands in ALUOut first
                alu_src_b = `SRC_B_IMM;
            end
            JALR: begin
                alu_src_a    = `SRC_A_OLD_PC;
                alu_src_b    = `SRC_B_FOUR;
                pc_write     = 1'b1;
                pc_source    = 1'b1;
                is_immediate = 1'b1;
            end
            AUIPC: begin
                alu_src_a = `SRC_A_OLD_PC;
                alu_src_b = `SRC_B_IMM;
            end
            LUI: begin
                alu_src_a = `SRC_A_ZERO;
                alu_src_b = `SRC_B_IMM;
            end
            EXECUTECSR: begin
                reg_write        = 1'b1;
                memory_to_reg    = `WB_CSR;
                csr_write_enable = 1'b1;
            end
            EXECUTE_MDU: begin
                alu_src_a = `SRC_A_RS1;
                mdu_start = 1'b1;
            end
            MDU_WAIT: begin
                alu_src_a = `SRC_A_RS1; // Operands stay on the bus until done
            end
            MDU_WB: begin
                reg_write     = 1'b1;
                memory_to_reg = `WB_MDU;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        mem_rw_exclusive: assert (!(memory_read && memory_write))
            else $error("Read and write strobes both active in state %s", state.name());
        ir_load_moves_pc: assert (!ir_write || pc_write)
            else $error("IR loaded without a PC update");
    end

endmodule

// File: design/control_unit.sv
`timescale 1ns/10ps

module control_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  control_unit_pkg::opcode_t    instruction_opcode,
    input  logic                         func7_lsb_bit,
    input  logic                         memory_response,
    input  logic                         mdu_done,
    output logic                         pc_write,
    output logic                         pc_write_cond,
    output logic                         pc_source,
    output logic                         ir_write,
    output logic                         reg_write,
    output logic                         memory_read,
    output logic                         memory_write,
    output logic                         is_immediate,
    output logic                         csr_write_enable,
    output logic                         save_address,
    output logic                         mdu_start,
    output control_unit_pkg::addr_sel_t  lord,
    output control_unit_pkg::aluop_t     aluop,
    output control_unit_pkg::alu_src_t   alu_src_a,
    output control_unit_pkg::alu_src_t   alu_src_b,
    output control_unit_pkg::wb_src_t    memory_to_reg
);

    import control_unit_pkg::*;

    instr_class_t instr_class;
    ctrl_state_t  state;

    opcode_decoder opcode_decoder_i (
        .instruction_opcode (instruction_opcode),
        .func7_lsb_bit      (func7_lsb_bit),
        .instr_class        (instr_class)
    );

    // Class is only consumed after DECODE, when the IR is stable
    state_sequencer state_sequencer_i (
        .clk             (clk),
        .reset           (reset),
        .instr_class     (instr_class),
        .memory_response (memory_response),
        .mdu_done        (mdu_done),
        .state           (state)
    );

    control_encoder control_encoder_i (
        .state            (state),
        .pc_write         (pc_write),
        .pc_write_cond    (pc_write_cond),
        .pc_source        (pc_source),
        .ir_write         (ir_write),
        .reg_write        (reg_write),
        .memory_read      (memory_read),
        .memory_write     (memory_write),
        .is_immediate     (is_immediate),
        .csr_write_enable (csr_write_enable),
        .save_address     (save_address),
        .mdu_start        (mdu_start),
        .lord             (lord),
        .aluop            (aluop),
        .alu_src_a        (alu_src_a),
        .alu_src_b        (alu_src_b),
        .memory_to_reg    (memory_to_reg)
    );

endmodule

// File: design/control_unit_pkg.sv
`include "control_unit_macros.svh"

package control_unit_pkg;

    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`CLASS_W-1:0]    instr_class_t;
    typedef logic [`SRC_W-1:0]      alu_src_t;
    typedef logic [`ADDR_SEL_W-1:0] addr_sel_t;
    typedef logic [`ALUOP_W-1:0]    aluop_t;
    typedef logic [`WB_SRC_W-1:0]   wb_src_t;

    // Encodings kept from the full core so waveforms line up
    typedef enum logic [`STATE_W-1:0] {
        FETCH          = 6'd0,
        DECODE         = 6'd1,
        MEMADR         = 6'd2,
        MEMREAD        = 6'd3,
        MEMWB          = 6'd4,
        MEMWRITE       = 6'd5,
        EXECUTER       = 6'd6,
        ALUWB          = 6'd7,
        EXECUTEI       = 6'd8,
        JAL            = 6'd9,
        BRANCH         = 6'd10,
        JALR           = 6'd11,
        AUIPC          = 6'd12,
        LUI            = 6'd13,
        JALR_PC        = 6'd14,
        EXECUTECSR     = 6'd15,
        VALIDATE_FETCH = 6'd46,
        EXECUTE_MDU    = 6'd47,
        MDU_WAIT       = 6'd48,
        MDU_WB         = 6'd49
    } ctrl_state_t;

endpackage

// File: design/opcode_decoder.sv
`timescale 1ns/10ps
`include "control_unit_macros.svh"

module opcode_decoder (
    input  control_unit_pkg::opcode_t      instruction_opcode,
    input  logic                           func7_lsb_bit,
    output control_unit_pkg::instr_class_t instr_class
);

    import control_unit_pkg::*;

    instr_class_t rtype_class;

    // funct7[0] set on an R-type opcode selects the M extension
    assign rtype_class = func7_lsb_bit ? `CLS_MDU : `CLS_ALU_R;

    always_comb begin
        instr_class = `CLS_ILLEGAL;
        case (instruction_opcode)
            `OP_LOAD: begin
                instr_class = `CLS_LOAD;
            end
            `OP_STORE: begin
                instr_class = `CLS_STORE;
            end
            `OP_RTYPE: begin
                instr_class = rtype_class;
            end
            `OP_ITYPE: begin
                instr_class = `CLS_ALU_I;
            end
            `OP_JAL: begin
                instr_class = `CLS_JAL;
            end
            `OP_JALR: begin
                instr_class = `CLS_JALR;
            end
            `OP_BRANCH: begin
                instr_class = `CLS_BRANCH;
            end
            `OP_AUIPC: begin
                instr_class = `CLS_AUIPC;
            end
            `OP_LUI: begin
                instr_class = `CLS_LUI;
            end
            `OP_SYSTEM: begin
                instr_class = `CLS_CSR; // Only CSR accesses use SYSTEM here
            end
            default: begin
                instr_class = `CLS_ILLEGAL;
            end
        endcase
    end

    // An unknown funct7 bit would leak into the class of an R-type word
    always_comb begin
        if (!$isunknown(instruction_opcode)) begin
            class_known: assert (!$isunknown(instr_class))
                else $error("Unknown class for opcode %b", instruction_opcode);
        end
    end

endmodule

// File: design/state_sequencer.sv
`timescale 1ns/10ps
`include "control_unit_macros.svh"

module state_sequencer (
    input  logic                           clk,
    input  logic                           reset,
    input  control_unit_pkg::instr_class_t instr_class,
    input  logic                           memory_response,
    input  logic                           mdu_done,
    output control_unit_pkg::ctrl_state_t  state
);

    import control_unit_pkg::*;

    ctrl_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = FETCH;
        case (state)
            FETCH: begin
                next_state = memory_response ? VALIDATE_FETCH : FETCH;
            end
            VALIDATE_FETCH: begin
                next_state = DECODE; // IR is loaded at the end of this cycle
            end
            DECODE: begin
                case (instr_class)
                    `CLS_LOAD,
                    `CLS_STORE: begin
                        next_state = MEMADR;
                    end
                    `CLS_ALU_R: begin
                        next_state = EXECUTER;
                    end
                    `CLS_ALU_I: begin
                        next_state = EXECUTEI;
                    end
                    `CLS_JAL: begin
                        next_state = JAL;
                    end
                    `CLS_JALR: begin
                        next_state = JALR_PC;
                    end
                    `CLS_BRANCH: begin
                        next_state = BRANCH;
                    end
                    `CLS_AUIPC: begin
                        next_state = AUIPC;
                    end
                    `CLS_LUI: begin
                        next_state = LUI;
                    end
                    `CLS_CSR: begin
                        next_state = EXECUTECSR;
                    end
                    `CLS_MDU: begin
                        next_state = EXECUTE_MDU;
                    end
                    default: begin
                        next_state = FETCH; // Illegal opcodes are dropped
                    end
                endcase
            end
            MEMADR: begin
                next_state = (instr_class == `CLS_LOAD) ? MEMREAD : MEMWRITE;
            end
            MEMREAD: begin
                next_state = memory_response ? MEMWB : MEMREAD;
            end
            MEMWRITE: begin
                next_state = memory_response ? FETCH : MEMWRITE;
            end
            EXECUTER,
            EXECUTEI,
            JAL,
            JALR,
            AUIPC,
            LUI: begin
                next_state = ALUWB;
            end
            JALR_PC: begin
                next_state = JALR;
            end
            EXECUTE_MDU: begin
                next_state = MDU_WAIT;
            end
            MDU_WAIT: begin
                next_state = mdu_done ? MDU_WB : MDU_WAIT;
            end
            default: begin
                next_state = FETCH; // MEMWB, ALUWB, BRANCH, EXECUTECSR, MDU_WB
            end
        endcase
    end

    // The MDU is only waited on after a start pulse was issued
    mdu_wait_entry: assert property (@(posedge clk) disable iff (reset)
        (state == MDU_WAIT) |-> $past(state == EXECUTE_MDU || state == MDU_WAIT))
        else $error("MDU_WAIT entered without EXECUTE_MDU");

    // The IR must only be loaded once the fetch has been answered
    fetch_validated: assert property (@(posedge clk) disable iff (reset)
        (state == VALIDATE_FETCH) |-> $past(state == FETCH && memory_response))
        else $error("VALIDATE_FETCH without a memory response");

endmodule

// File: filelist.f
+incdir+include
design/control_unit_pkg.sv
design/opcode_decoder.sv
design/state_sequencer.sv
design/control_encoder.sv
design/control_unit.sv
sim/control_unit_tb.sv

// File: include/control_unit_macros.svh
`ifndef CONTROL_UNIT_MACROS_SVH
`define CONTROL_UNIT_MACROS_SVH

// Field and select widths
`define OPCODE_W   7
`define CLASS_W    4
`define SRC_W      3
`define ADDR_SEL_W 2
`define ALUOP_W    2
`define WB_SRC_W   3
`define STATE_W    6

// RV32 major opcodes
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_RTYPE  7'b0110011
`define OP_ITYPE  7'b0010011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_AUIPC  7'b0010111
`define OP_LUI    7'b0110111
`define OP_SYSTEM 7'b1110011

// Instruction classes from the opcode decoder
`define CLS_LOAD    4'd0
`define CLS_STORE   4'd1
`define CLS_ALU_R   4'd2
`define CLS_ALU_I   4'd3
`define CLS_JAL     4'd4
`define CLS_JALR    4'd5
`define CLS_BRANCH  4'd6
`define CLS_AUIPC   4'd7
`define CLS_LUI     4'd8
`define CLS_CSR     4'd9
`define CLS_MDU     4'd10
`define CLS_ILLEGAL 4'd15

// ALU operand selects
`define SRC_A_PC     3'b000
`define SRC_A_RS1    3'b001
`define SRC_A_OLD_PC 3'b010
`define SRC_A_ZERO   3'b011
`define SRC_B_RS2    3'b000
`define SRC_B_FOUR   3'b001
`define SRC_B_IMM    3'b010

// Memory address source and write-back source
`define ADDR_PC  2'b00
`define ADDR_ALU 2'b01
`define WB_ALU   3'b000
`define WB_MEM   3'b001
`define WB_CSR   3'b010
`define WB_MDU   3'b111

// ALU operation family, refined by funct3/funct7 in the ALU control
`define ALUOP_ADD    2'b00
`define ALUOP_BRANCH 2'b01
`define ALUOP_FUNCT  2'b10

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f filelist.f \
    --top-module control_unit_tb \
    --Mdir obj_dir \
    -o control_unit_tb

./obj_dir/control_unit_tb

// File: sim/control_unit_tb.sv
`timescale 1ns/10ps
`include "control_unit_macros.svh"

module control_unit_tb;

    import control_unit_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int PASSES = 2;

    logic clk = 1'b0;
    logic reset = 1'b1;
    opcode_t instruction_opcode = '0;
    logic func7_lsb_bit = 1'b0;
    logic memory_response = 1'b0;
    logic mdu_done = 1'b0;
    logic pc_write, pc_write_cond, pc_source, ir_write, reg_write, memory_read;
    logic memory_write, is_immediate, csr_write_enable, save_address, mdu_start;
    addr_sel_t lord;
    aluop_t aluop;
    alu_src_t alu_src_a, alu_src_b;
    wb_src_t memory_to_reg;

    // Stimulus table, one entry per instruction
    opcode_t row_opcode[$];
    wb_src_t row_wb[$];
    logic row_f7[$], row_mem_wr[$], row_csr[$];
    int row_extra[$], row_regs[$], row_pcs[$], row_mdus[$];

    int fetch_wait = 0;
    int data_wait = 0;
    int mdu_wait = 0;
    int mem_cycles = 0;
    int mdu_cycles = 0;
    logic mdu_pending = 1'b0;
    int cycle_count = 0;
    int cycle_limit = 0;

    control_unit dut_i (.*);

    always #20 clk = ~clk;

    task automatic add_row(input opcode_t op, input logic f7, input int extra, input int regs,
                           input wb_src_t wb, input int pcs, input int mdus,
                           input logic mem_wr, input logic csr_we);
        row_opcode.push_back(op);
        row_f7.push_back(f7);
        row_extra.push_back(extra);
        row_regs.push_back(regs);
        row_wb.push_back(wb);
        row_pcs.push_back(pcs);
        row_mdus.push_back(mdus);
        row_mem_wr.push_back(mem_wr);
        row_csr.push_back(csr_we);
    endtask

    task automatic load_table();
        add_row(`OP_LOAD,   1'b0, 3, 1, `WB_MEM, 0, 0, 1'b0, 1'b0);
        add_row(`OP_STORE,  1'b0, 2, 0, `WB_ALU, 0, 0, 1'b1, 1'b0);
        add_row(`OP_RTYPE,  1'b0, 2, 1, `WB_ALU, 0, 0, 1'b0, 1'b0);
        add_row(`OP_ITYPE,  1'b0, 2, 1, `WB_ALU, 0, 0, 1'b0, 1'b0);
        add_row(`OP_ITYPE,  1'b1, 2, 1, `WB_ALU, 0, 0, 1'b0, 1'b0); // funct7 bit is ignored
        add_row(`OP_JAL,    1'b0, 2, 1, `WB_ALU, 1, 0, 1'b0, 1'b0);
        add_row(`OP_JALR,   1'b0, 3, 1, `WB_ALU, 1, 0, 1'b0, 1'b0);
        add_row(`OP_BRANCH, 1'b0, 1, 0, `WB_ALU, 0, 0, 1'b0, 1'b0);
        add_row(`OP_AUIPC,  1'b0, 2, 1, `WB_ALU, 0, 0, 1'b0, 1'b0);
        add_row(`OP_LUI,    1'b0, 2, 1, `WB_ALU, 0, 0, 1'b0, 1'b0);
        add_row(`OP_SYSTEM, 1'b0, 1, 1, `WB_CSR, 0, 0, 1'b0, 1'b1);
        add_row(`OP_RTYPE,  1'b1, 3, 1, `WB_MDU, 0, 1, 1'b0, 1'b0);
        add_row(7'b1111111, 1'b0, 0, 0, `WB_ALU, 0, 0, 1'b0, 1'b0);
        add_row(7'b0001111, 1'b0, 0, 0, `WB_ALU, 0, 0, 1'b0, 1'b0); // FENCE is not supported
    endtask

    function automatic int row_length(input int idx, input int f, input int d, input int m);
        int len;
        len = 3 + f + row_extra[idx];
        if (row_opcode[idx] == `OP_LOAD || row_opcode[idx] == `OP_STORE) len += d;
        if (row_opcode[idx] == `OP_RTYPE && row_f7[idx]) len += m;
        return len;
    endfunction

    function automatic int timeout_limit();
        int total;
        total = RESET_CYCLES + 8;
        for (int i = 0; i < row_opcode.size(); i++) total += PASSES * row_length(i, 3, 3, 3);
        return 2 * total;
    endfunction

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_count(input string what, input int actual, input int expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_wb_src(input string what, input wb_src_t actual, input wb_src_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_addr_sel(input string what, input addr_sel_t actual,
                                  input addr_sel_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_aluop(input string what, input aluop_t actual, input aluop_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_alu_src(input string what, input alu_src_t actual,
                                 input alu_src_t expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Memory answers after the chosen number of low cycles, fetch and data apart
    always @(posedge clk) begin : memory_responder
        logic busy;
        int wait_now;
        #1;
        busy = (memory_read || memory_write) && !ir_write && !reset;
        wait_now = (lord == `ADDR_ALU) ? data_wait : fetch_wait;
        #1;
        if (!busy) begin
            memory_response = 1'b0;
            mem_cycles = 0;
        end else if (mem_cycles == wait_now) begin
            memory_response = 1'b1;
            mem_cycles = 0;
        end else begin
            memory_response = 1'b0;
            mem_cycles++;
        end
    end

    always @(posedge clk) begin : mdu_responder
        logic started;
        #1;
        started = mdu_start;
        #1;
        mdu_done = 1'b0;
        if (started) begin
            mdu_pending = 1'b1;
            mdu_cycles = 0;
        end else if (mdu_pending && mdu_cycles == mdu_wait) begin
            mdu_done = 1'b1;
            mdu_pending = 1'b0;
        end else if (mdu_pending) begin
            mdu_cycles++;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the instruction sequence did not finish in %0d cycles", cycle_count);
            abort_run();
        end
    end

    initial begin : main_sequence
        int n_len, n_reg, n_pc, n_cond, n_mdu, n_rd, n_addr;
        logic wr_seen, csr_seen, imm_seen;
        void'($urandom(46));
        load_table();
        cycle_limit = timeout_limit();
        fetch_wait = $urandom % 4;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        do begin
            next_cycle();
            if (!ir_write) begin
                check_flag("memory_read after reset", memory_read, 1'b1);
                check_flag("memory_write after reset", memory_write, 1'b0);
                check_flag("reg_write after reset", reg_write, 1'b0);
                check_flag("pc_write after reset", pc_write, 1'b0);
                check_flag("pc_write_cond after reset", pc_write_cond, 1'b0);
                check_flag("pc_source after reset", pc_source, 1'b0);
                check_flag("is_immediate after reset", is_immediate, 1'b0);
                check_flag("csr_write_enable after reset", csr_write_enable, 1'b0);
                check_flag("save_address after reset", save_address, 1'b0);
                check_flag("mdu_start after reset", mdu_start, 1'b0);
                check_addr_sel("lord during first fetch", lord, `ADDR_PC);
            end
        end while (!ir_write);
        for (int round = 0; round < PASSES; round++) begin
            for (int i = 0; i < row_opcode.size(); i++) begin
                #1;
                instruction_opcode = row_opcode[i]; // New word is valid from DECODE on
                func7_lsb_bit = row_f7[i];
                fetch_wait = $urandom % 4;
                data_wait = $urandom % 4;
                mdu_wait = $urandom % 4;
                n_len = 0;
                n_reg = 0;
                n_pc = 0;
                n_cond = 0;
                n_mdu = 0;
                n_rd = 0;
                n_addr = 0;
                wr_seen = 1'b0;
                csr_seen = 1'b0;
                imm_seen = 1'b0;
                do begin
                    next_cycle();
                    n_len++;
                    if (!ir_write) begin
                        if (reg_write) begin
                            n_reg++;
                            check_wb_src($sformatf("row %0d memory_to_reg", i), memory_to_reg,
                                         row_wb[i]);
                        end
                        if (memory_write) begin
                            wr_seen = 1'b1;
                            check_addr_sel($sformatf("row %0d store lord", i), lord, `ADDR_ALU);
                        end
                        if (csr_write_enable) begin
                            csr_seen = 1'b1;
                            check_flag($sformatf("row %0d CSR reg_write", i), reg_write, 1'b1);
                        end
                        if (save_address) begin
                            n_addr++;
                            check_alu_src($sformatf("row %0d address operand A", i), alu_src_a,
                                          `SRC_A_RS1);
                            check_alu_src($sformatf("row %0d address operand B", i), alu_src_b,
                                          `SRC_B_IMM);
                        end
                        if (pc_write_cond) begin
                            check_aluop($sformatf("row %0d branch aluop", i), aluop,
                                        `ALUOP_BRANCH);
                        end
                        if (pc_write || pc_write_cond) begin
                            check_flag($sformatf("row %0d jump pc_source", i), pc_source, 1'b1);
                        end
                        imm_seen |= is_immediate;
                        n_pc += pc_write;
                        n_cond += pc_write_cond;
                        n_mdu += mdu_start;
                        n_rd += (memory_read && lord == `ADDR_ALU);
                    end
                end while (!ir_write);
                // The IR load cycle also moves the PC on by four
                check_alu_src($sformatf("row %0d PC increment operand A", i), alu_src_a,
                              `SRC_A_PC);
                check_alu_src($sformatf("row %0d PC increment operand B", i), alu_src_b,
                              `SRC_B_FOUR);
                check_aluop($sformatf("row %0d PC increment aluop", i), aluop, `ALUOP_ADD);
                check_count($sformatf("row %0d cycle count", i), n_len,
                            row_length(i, fetch_wait, data_wait, mdu_wait));
                check_count($sformatf("row %0d reg_write pulses", i), n_reg, row_regs[i]);
                check_count($sformatf("row %0d pc_write pulses", i), n_pc, row_pcs[i]);
                check_count($sformatf("row %0d mdu_start pulses", i), n_mdu, row_mdus[i]);
                check_count($sformatf("row %0d pc_write_cond pulses", i), n_cond,
                            (row_opcode[i] == `OP_BRANCH) ? 1 : 0);
                check_count($sformatf("row %0d data read cycles", i), n_rd,
                            (row_opcode[i] == `OP_LOAD) ? 1 + data_wait : 0);
                check_count($sformatf("row %0d save_address pulses", i), n_addr,
                            (row_opcode[i] == `OP_LOAD || row_opcode[i] == `OP_STORE) ? 1 : 0);
                check_flag($sformatf("row %0d memory_write seen", i), wr_seen, row_mem_wr[i]);
                check_flag($sformatf("row %0d csr_write_enable seen", i), csr_seen, row_csr[i]);
                check_flag($sformatf("row %0d is_immediate seen", i), imm_seen,
                           row_opcode[i] == `OP_ITYPE || row_opcode[i] == `OP_JALR);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
